/* Makefile */
# Verilator build and run of the arcade board shell testbench

OBJ_DIR = obj_dir
LOG     = sim.log

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --assert --timescale 1ns/100ps \
	    --top-module tb_arcade_board -f filelist.f \
	    -Mdir $(OBJ_DIR) -o tb_arcade_board

# The log decides pass or fail
run: compile
	./$(OBJ_DIR)/tb_arcade_board | tee $(LOG)
	grep -q "Simulation PASSED" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

/* filelist.f */
source/board_cfg_pkg.sv
source/video_pkg.sv
source/dip_decoder.sv
source/video_gen.sv
source/pixel_fifo.sv
source/video_out.sv
source/arcade_board_top.sv
sim/tb_arcade_board.sv

/* sim/tb_arcade_board.sv */
// ************************************************************
// Testbench for the arcade board shell. Drives a new menu status
// word at the start of every frame, follows the raster with its
// own counters and checks reset values, DIP decoding and every
// output pixel with concurrent assertions over a fixed number
// of frames. A watchdog ends a run that stalls.
// ************************************************************

`default_nettype none

module tb_arcade_board;

    timeunit 1ns;
    timeprecision 100ps;

    localparam int h_total      = 16;
    localparam int h_active     = 12;
    localparam int v_total      = 10;
    localparam int v_active     = 8;
    localparam int fifo_depth   = 4;
    localparam int num_frames   = 12;
    localparam int clk_period   = 100;
    localparam int reset_cycles = 16;
    // Two clocks per pixel, plus reset and some slack
    localparam int timeout_ns   = num_frames * h_total * v_total * 2 * clk_period
                                  + reset_cycles * clk_period + 200 * clk_period;

    logic                    clk_rgb;
    logic                    arst_n;
    logic [31:0]             status;
    board_cfg_pkg::dip_cfg_t dip;
    video_pkg::out_pixel_t   video;
    logic                    pxl_strobe;

    board_cfg_pkg::dip_cfg_t exp_dip;       // Reference of the DIP register
    board_cfg_pkg::dip_cfg_t cur_cfg;       // Settings of the frame on screen
    video_pkg::out_pixel_t   exp_video;
    logic                    reset_window;
    logic [31:0]             rnd;
    int                      m_h;
    int                      m_v;
    int                      m_frame;
    int                      frames_done;

    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    // Random word with level, pause and filter set by frame number
    function automatic logic [31:0] frame_status(input int n, input logic [31:0] r);
        logic [31:0] s;
        s      = r;
        s[3:2] = n[1:0];                    // Each menu difficulty code in turn
        s[1]   = (n >= 6 && n <= 8);        // Paused frames
        s[9]   = !(n >= 3 && n <= 8);       // Clear bit turns the filter on
        return s;
    endfunction

    function automatic board_cfg_pkg::dip_cfg_t decode_status(input logic [31:0] s);
        board_cfg_pkg::dip_cfg_t d;
        d.pause     = s[1];
        d.lives     = s[6:5];
        d.en_filter = !s[9];
        if (s[3:2] == 2'b00) d.level = board_cfg_pkg::level_normal;
        else if (s[3:2] == 2'b01) d.level = board_cfg_pkg::level_easy;
        else if (s[3:2] == 2'b10) d.level = board_cfg_pkg::level_hard;
        else d.level = board_cfg_pkg::level_very_hard;
        return d;
    endfunction

    function automatic logic [3:0] expected_colour(input int c, input bit blank, input bit dim);
        int wide;
        wide = 2 * c + ((c >= 4) ? 1 : 0);  // Top bit copied below the others
        if (blank) begin
            wide = 0;
        end else if (dim) begin
            wide = wide / 2;
        end
        return 4'(wide);
    endfunction

    task automatic abort_run();
        $display("Simulation FAILED");
        $fatal(1);
    endtask

    task automatic report_mismatch(input string sig, input int unsigned exp,
                                   input int unsigned act);
        $display("error at %0t ns: %s expected 0x%0h actual 0x%0h", $time, sig, exp, act);
        abort_run();
    endtask

    // Expected output for the strobed pixel, then the model steps on
    task automatic follow_pixel();
        bit blank;
        bit dim;
        blank = (m_h >= h_active) || (m_v >= v_active);
        dim   = cur_cfg.en_filter && (m_v % 2 == 1);
        exp_video.red   = expected_colour(m_h % 8, blank, dim);
        exp_video.green = expected_colour(m_v % 8, blank, dim);
        exp_video.blue  = expected_colour(m_frame % 8, blank, dim);
        exp_video.hs    = (m_h >= h_active);
        exp_video.vs    = (m_v >= v_active);
        if (m_h == 0 && m_v == 0) begin
            rnd     = xorshift32(rnd);
            status  = frame_status(frames_done, rnd);
            cur_cfg = decode_status(status);
        end
        if (m_h == h_total - 1 && m_v == v_total - 1) begin
            m_h = 0;
            m_v = 0;
            if (!cur_cfg.pause) m_frame++;
            frames_done++;
        end else if (m_h == h_total - 1) begin
            m_h = 0;
            m_v++;
        end else begin
            m_h++;
        end
    endtask

    arcade_board_top #(
        .h_total    ( h_total    ),
        .h_active   ( h_active   ),
        .v_total    ( v_total    ),
        .v_active   ( v_active   ),
        .fifo_depth ( fifo_depth )
    ) UUT (
        .clk_rgb    ( clk_rgb    ),
        .arst_n     ( arst_n     ),
        .status     ( status     ),
        .dip        ( dip        ),
        .video      ( video      ),
        .pxl_strobe ( pxl_strobe )
    );

    initial begin
        clk_rgb = 1'b0;
        forever #(clk_period / 2) clk_rgb = ~clk_rgb;
    end

    always @(posedge clk_rgb or negedge arst_n) begin
        if (!arst_n) begin
            exp_dip <= '0;
        end else begin
            exp_dip <= decode_status(status);
        end
    end

    assert property (@(posedge clk_rgb) reset_window |-> !pxl_strobe)
        else report_mismatch("pxl_strobe", 0, 32'($sampled(pxl_strobe)));
    assert property (@(posedge clk_rgb) reset_window |-> video == '0)
        else report_mismatch("video", 0, 32'($sampled(video)));

    assert property (@(posedge clk_rgb) disable iff (!arst_n) dip.level == exp_dip.level)
        else report_mismatch("dip.level", 32'($sampled(exp_dip.level)),
                             32'($sampled(dip.level)));
    assert property (@(posedge clk_rgb) disable iff (!arst_n) dip.lives == exp_dip.lives)
        else report_mismatch("dip.lives", 32'($sampled(exp_dip.lives)),
                             32'($sampled(dip.lives)));
    assert property (@(posedge clk_rgb) disable iff (!arst_n) dip.pause == exp_dip.pause)
        else report_mismatch("dip.pause", 32'($sampled(exp_dip.pause)),
                             32'($sampled(dip.pause)));
    assert property (@(posedge clk_rgb) disable iff (!arst_n)
                     dip.en_filter == exp_dip.en_filter)
        else report_mismatch("dip.en_filter", 32'($sampled(exp_dip.en_filter)),
                             32'($sampled(dip.en_filter)));

    // Output pixel checks, one per strobe
    assert property (@(posedge clk_rgb) pxl_strobe |-> video.red == exp_video.red)
        else report_mismatch("video.red", 32'($sampled(exp_video.red)),
                             32'($sampled(video.red)));
    assert property (@(posedge clk_rgb) pxl_strobe |-> video.green == exp_video.green)
        else report_mismatch("video.green", 32'($sampled(exp_video.green)),
                             32'($sampled(video.green)));
    assert property (@(posedge clk_rgb) pxl_strobe |-> video.blue == exp_video.blue)
        else report_mismatch("video.blue", 32'($sampled(exp_video.blue)),
                             32'($sampled(video.blue)));
    assert property (@(posedge clk_rgb) pxl_strobe |-> video.hs == exp_video.hs)
        else report_mismatch("video.hs", 32'($sampled(exp_video.hs)),
                             32'($sampled(video.hs)));
    assert property (@(posedge clk_rgb) pxl_strobe |-> video.vs == exp_video.vs)
        else report_mismatch("video.vs", 32'($sampled(exp_video.vs)),
                             32'($sampled(video.vs)));

    initial begin
        #(timeout_ns);
        $display("timeout: %0d frames were not seen within %0d ns", num_frames, timeout_ns);
        abort_run();
    end

    initial begin
        arst_n       = 1'b0;
        reset_window = 1'b0;
        rnd          = 32'd6747;
        status       = frame_status(0, rnd);
        cur_cfg      = decode_status(status);
        exp_video    = '0;
        m_h          = 0;
        m_v          = 0;
        m_frame      = 0;
        frames_done  = 0;
        repeat (2) @(negedge clk_rgb);
        reset_window = 1'b1;            // Registers have seen a reset edge
        repeat (reset_cycles - 2) @(negedge clk_rgb);
        arst_n = 1'b1;
        repeat (2) @(negedge clk_rgb);
        reset_window = 1'b0;
        while (frames_done < num_frames) begin
            @(negedge clk_rgb);
            if (pxl_strobe) begin
                follow_pixel();
            end
        end
        repeat (2) @(negedge clk_rgb);  // Last pixel checked
        $display("Simulation PASSED");
        $finish;
    end

endmodule

`default_nettype wire

/* source/arcade_board_top.sv */
// ************************************************************
// Top level of the arcade board shell. Sets the raster and FIFO
// sizes and connects the DIP decoder, the game video generator,
// the pixel FIFO and the output stage. The decoded DIP struct
// is exported next to the output video and its pixel strobe.
// ************************************************************

`default_nettype none

module arcade_board_top #(
    parameter int h_total    = 16,
    parameter int h_active   = 12,
    parameter int v_total    = 10,
    parameter int v_active   = 8,
    parameter int fifo_depth = 4     // Power of two
) (
    input  wire logic                clk_rgb,
    input  wire logic                arst_n,
    input  wire logic [31:0]         status,
    output board_cfg_pkg::dip_cfg_t  dip,
    output video_pkg::out_pixel_t    video,
    output logic                     pxl_strobe
);

    logic                   push;
    video_pkg::game_pixel_t push_pixel;
    logic                   pop;
    logic                   empty;
    video_pkg::game_pixel_t pop_pixel;

    dip_decoder u_dip (
        .clk_rgb    ( clk_rgb    ),
        .arst_n     ( arst_n     ),
        .status     ( status     ),
        .dip        ( dip        )
    );

    video_gen #(
        .h_total    ( h_total    ),
        .h_active   ( h_active   ),
        .v_total    ( v_total    ),
        .v_active   ( v_active   )
    ) u_gen (
        .clk_rgb    ( clk_rgb    ),
        .arst_n     ( arst_n     ),
        .pause      ( dip.pause  ),
        .push       ( push       ),
        .push_pixel ( push_pixel )
    );

    pixel_fifo #(
        .fifo_depth ( fifo_depth )
    ) u_fifo (
        .clk_rgb    ( clk_rgb    ),
        .arst_n     ( arst_n     ),
        .push       ( push       ),
        .push_pixel ( push_pixel ),
        .pop        ( pop        ),
        .empty      ( empty      ),
        .pop_pixel  ( pop_pixel  )
    );

    video_out u_out (
        .clk_rgb    ( clk_rgb       ),
        .arst_n     ( arst_n        ),
        .empty      ( empty         ),
        .pop        ( pop           ),
        .pop_pixel  ( pop_pixel     ),
        .en_filter  ( dip.en_filter ),
        .video      ( video         ),
        .pxl_strobe ( pxl_strobe    )
    );

endmodule

`default_nettype wire

/* source/board_cfg_pkg.sv */
// ************************************************************
// Board configuration definitions shared by the arcade shell.
// Bit positions of the menu status word, the difficulty code
// as the game sees it and the decoded DIP settings struct.
// Referenced by scoped names from the decoder, the video
// blocks and the top level.
// ************************************************************

`default_nettype none

package board_cfg_pkg;

    // Positions inside the 32-bit menu status word
    localparam int status_pause_bit  = 1;
    localparam int status_level_lsb  = 2;   // Two bits, 3:2
    localparam int status_lives_lsb  = 5;   // Two bits, 6:5
    localparam int status_filter_bit = 9;   // Set means filter off

    // Difficulty code at the game side
    typedef enum logic [1:0] {
        level_easy      = 2'd0,
        level_normal    = 2'd1,
        level_hard      = 2'd2,
        level_very_hard = 2'd3
    } level_e;

    // Decoded DIP settings, all zero after reset
    typedef struct packed {
        logic       pause;
        level_e     level;
        logic [1:0] lives;
        logic       en_filter;  // Scanline dimming on odd lines
    } dip_cfg_t;

endpackage

`default_nettype wire

/* source/dip_decoder.sv */
// ************************************************************
// Latches the menu status word on the board clock and turns
// it into the DIP settings seen by the game and video blocks.
// One clock from status to dip. Difficulty is remapped and the
// screen filter bit is inverted.
// ************************************************************

`default_nettype none

module dip_decoder (
    input  wire logic                    clk_rgb,
    input  wire logic                    arst_n,
    input  wire logic [31:0]             status,
    output board_cfg_pkg::dip_cfg_t      dip
);

    board_cfg_pkg::dip_cfg_t dip_next;
    logic [1:0]              level_code;

    assign level_code = status[board_cfg_pkg::status_level_lsb +: 2];

    always_comb begin
        // Menu order differs from the game order
        case (level_code)
            2'b00:   dip_next.level = board_cfg_pkg::level_normal;
            2'b01:   dip_next.level = board_cfg_pkg::level_easy;
            2'b10:   dip_next.level = board_cfg_pkg::level_hard;
            default: dip_next.level = board_cfg_pkg::level_very_hard;
        endcase
        dip_next.pause     = status[board_cfg_pkg::status_pause_bit];
        dip_next.lives     = status[board_cfg_pkg::status_lives_lsb +: 2];
        dip_next.en_filter = ~status[board_cfg_pkg::status_filter_bit]; // Menu bit means off
    end

    // All game inputs latched together
    always_ff @(posedge clk_rgb or negedge arst_n) begin
        if (!arst_n) begin
            dip <= '0;  // Easy, filter off
        end else begin
            dip <= dip_next;
        end
    end

endmodule

`default_nettype wire

/* source/pixel_fifo.sv */
// ************************************************************
// Register-array FIFO of game pixels between the generator and
// the output stage. Push stores a pixel unless the FIFO is full,
// pop removes the head at the clock edge. The head entry is
// always visible on pop_pixel.
// ************************************************************

`default_nettype none

module pixel_fifo #(
    parameter int fifo_depth = 4
) (
    input  wire logic                   clk_rgb,
    input  wire logic                   arst_n,
    input  wire logic                   push,
    input  wire video_pkg::game_pixel_t push_pixel,
    input  wire logic                   pop,
    output logic                        empty,
    output video_pkg::game_pixel_t      pop_pixel
);

    localparam int aw = (fifo_depth > 1) ? $clog2(fifo_depth) : 1;
    localparam int cw = $clog2(fifo_depth + 1);

    video_pkg::game_pixel_t mem [fifo_depth];

    logic [aw-1:0] wr_ptr;
    logic [aw-1:0] rd_ptr;
    logic [cw-1:0] count;
    logic          full;
    logic          wr_en;
    logic          rd_en;

    assign empty = (count == '0);
    assign full  = (count == cw'(fifo_depth));
    assign wr_en = push && !full;   // Pushes on full are lost
    assign rd_en = pop && !empty;

    assign pop_pixel = mem[rd_ptr];

    always_ff @(posedge clk_rgb) begin
        if (wr_en) begin
            mem[wr_ptr] <= push_pixel;
        end
    end

    always_ff @(posedge clk_rgb or negedge arst_n) begin
        if (!arst_n) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (wr_en) begin
                wr_ptr <= (wr_ptr == aw'(fifo_depth - 1)) ? '0 : wr_ptr + 1'b1;
            end
            if (rd_en) begin
                rd_ptr <= (rd_ptr == aw'(fifo_depth - 1)) ? '0 : rd_ptr + 1'b1;
            end
            case ({wr_en, rd_en})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;    // Both or neither
            endcase
        end
    end

endmodule

`default_nettype wire

/* source/video_gen.sv */
// ************************************************************
// Game-side video generator standing in for the game module.
// Divides the board clock by two into a pixel enable, runs the
// raster and frame counters and pushes one test pixel per
// enable into the pixel FIFO, one clock after the enable.
// Pause freezes the frame counter, the raster keeps running.
// ************************************************************

`default_nettype none

module video_gen #(
    parameter int h_total  = 16,
    parameter int h_active = 12,
    parameter int v_total  = 10,
    parameter int v_active = 8
) (
    input  wire logic              clk_rgb,
    input  wire logic              arst_n,
    input  wire logic              pause,
    output logic                   push,
    output video_pkg::game_pixel_t push_pixel
);

    // Counters at least as wide as one colour
    localparam int hw = ($clog2(h_total) < video_pkg::colour_w) ?
                        video_pkg::colour_w : $clog2(h_total);
    localparam int vw = ($clog2(v_total) < video_pkg::colour_w) ?
                        video_pkg::colour_w : $clog2(v_total);

    logic                            pxl_cen;
    logic [hw-1:0]                   h_count;
    logic [vw-1:0]                   v_count;
    logic [video_pkg::colour_w-1:0]  frame_count;
    logic                            line_end;
    logic                            frame_end;

    assign line_end  = (h_count == hw'(h_total - 1));
    assign frame_end = line_end && (v_count == vw'(v_total - 1));

    // Pixel enable at half the board clock
    always_ff @(posedge clk_rgb or negedge arst_n) begin
        if (!arst_n) begin
            pxl_cen <= 1'b0;
        end else begin
            pxl_cen <= ~pxl_cen;
        end
    end

    always_ff @(posedge clk_rgb or negedge arst_n) begin
        if (!arst_n) begin
            h_count     <= '0;
            v_count     <= '0;
            frame_count <= '0;
        end else if (pxl_cen) begin
            h_count <= line_end ? '0 : h_count + 1'b1;
            if (line_end) begin
                v_count <= frame_end ? '0 : v_count + 1'b1;
            end
            if (frame_end && !pause) begin
                frame_count <= frame_count + 1'b1;  // Blue freezes on pause
            end
        end
    end

    always_ff @(posedge clk_rgb or negedge arst_n) begin
        if (!arst_n) begin
            push <= 1'b0;
        end else begin
            push <= pxl_cen;
        end
    end

    // Test picture, sampled from the counters before they advance
    always_ff @(posedge clk_rgb) begin
        if (pxl_cen) begin
            push_pixel.red      <= h_count[video_pkg::colour_w-1:0];
            push_pixel.green    <= v_count[video_pkg::colour_w-1:0];
            push_pixel.blue     <= frame_count;
            push_pixel.hb       <= (h_count >= hw'(h_active));
            push_pixel.vb       <= (v_count >= vw'(v_active));
            push_pixel.line_odd <= v_count[0];
        end
    end

endmodule

`default_nettype wire

/* source/video_out.sv */
// ************************************************************
// Output stage of the board shell. Pops a game pixel whenever
// the FIFO holds one, widens each colour from 3 to 4 bits,
// blacks out blanked pixels, dims odd lines when the screen
// filter is on and registers the result with sync and a strobe.
// ************************************************************

`default_nettype none

module video_out (
    input  wire logic                   clk_rgb,
    input  wire logic                   arst_n,
    input  wire logic                   empty,
    output logic                        pop,
    input  wire video_pkg::game_pixel_t pop_pixel,
    input  wire logic                   en_filter,
    output video_pkg::out_pixel_t       video,
    output logic                        pxl_strobe
);

    logic                  blank;
    logic                  dim;
    video_pkg::out_pixel_t video_next;

    // Top bit repeated into the new LSB, then optional dimming
    function automatic logic [video_pkg::out_colour_w-1:0] widen(
        input logic [video_pkg::colour_w-1:0] c,
        input logic                           half
    );
        logic [video_pkg::out_colour_w-1:0] w;
        w = {c, c[video_pkg::colour_w-1]};
        return half ? (w >> 1) : w;
    endfunction

    assign pop   = !empty;  // No back-pressure
    assign blank = pop_pixel.hb || pop_pixel.vb;
    assign dim   = en_filter && pop_pixel.line_odd;   // Scanline effect

    always_comb begin
        video_next.red   = blank ? '0 : widen(pop_pixel.red, dim);
        video_next.green = blank ? '0 : widen(pop_pixel.green, dim);
        video_next.blue  = blank ? '0 : widen(pop_pixel.blue, dim);
        video_next.hs    = pop_pixel.hb;
        video_next.vs    = pop_pixel.vb;
    end

    always_ff @(posedge clk_rgb or negedge arst_n) begin
        if (!arst_n) begin
            video      <= '0;
            pxl_strobe <= 1'b0;
        end else begin
            pxl_strobe <= pop;
            if (pop) begin
                video <= video_next;    // Held between pixels
            end
        end
    end

endmodule

`default_nettype wire

/* source/video_pkg.sv */
// ************************************************************
// Video definitions for the game pixel stream and the output.
// The game side delivers 3 bits per colour with blanking and
// line parity, the output stage 4 bits per colour with sync.
// ************************************************************

`default_nettype none

package video_pkg;

    localparam int colour_w     = 3;    // Game colour width
    localparam int out_colour_w = 4;    // Output colour width

    // One game pixel as it travels through the FIFO
    typedef struct packed {
        logic [colour_w-1:0] red;
        logic [colour_w-1:0] green;
        logic [colour_w-1:0] blue;
        logic                hb;
        logic                vb;
        logic                line_odd;
    } game_pixel_t;

    // Output pixel with sync
    typedef struct packed {
        logic [out_colour_w-1:0] red;
        logic [out_colour_w-1:0] green;
        logic [out_colour_w-1:0] blue;
        logic                    hs;
        logic                    vs;
    } out_pixel_t;

endpackage

`default_nettype wire
